//--- isaPkg.sv
`default_nettype none

package isaPkg;

  // Register file geometry
  localparam int RegCount = 32;
  localparam int RegIdxW  = $clog2(RegCount);

  // Data RAM geometry, word indexed from address bits 7:2
  localparam int RamWords = 64;
  localparam int RamIdxW  = $clog2(RamWords);

  typedef logic [RegIdxW-1:0] regIdxT;   // Architectural register number
  typedef logic [31:0]        wordT;     // Data word

  // Pre-decoded operation codes
  typedef enum logic [3:0] {
    opAdd   = 4'd0,
    opSub   = 4'd1,
    opAnd   = 4'd2,
    opOr    = 4'd3,
    opXor   = 4'd4,
    opAddi  = 4'd5,   // rs1 + imm
    opLoad  = 4'd6,   // rd <- mem[rs1 + imm]
    opStore = 4'd7,   // mem[rs1 + imm] <- rs2, no rd
    opMul   = 4'd8,   // Low word of rs1 * rs2
    opCsrw  = 4'd9,   // csr <- rs1, no rd
    opCsrr  = 4'd10   // rd <- csr
  } opT;

endpackage

`default_nettype wire

//--- pipePkg.sv
`default_nettype none

package pipePkg;
  import isaPkg::*;

  // Bypass source for an Execute operand, same encoding as the classic forward mux
  typedef enum logic [1:0] {
    fwdNone = 2'b00,   // Register file value
    fwdW    = 2'b01,   // Writeback stage result
    fwdM    = 2'b10    // Memory stage result
  } fwdSelT;

  // Decode to Execute
  typedef struct packed {
    opT     op;
    regIdxT rs1;     // x0 when the op has no rs1
    regIdxT rs2;     // x0 when the op has no rs2
    regIdxT rd;      // x0 when the op writes nothing
    wordT   imm;
    wordT   a;       // Register file operand A
    wordT   b;       // Register file operand B
    logic   write;
  } deStageT;

  // Execute to Memory
  typedef struct packed {
    opT          op;
    regIdxT      rd;
    wordT        alu;         // ALU result, RAM address or CSR write data
    wordT        storeData;
    wordT        pLo;         // aLo * bLo
    logic [15:0] pCross;      // Low half of aHi * bLo + aLo * bHi
    logic        write;
  } emStageT;

  // Memory to Writeback
  typedef struct packed {
    regIdxT rd;
    wordT   result;
    logic   write;
  } mwStageT;

endpackage

`default_nettype wire

//--- hazardIf.sv
`default_nettype none

interface hazardIf import isaPkg::*, pipePkg::*; (
  input logic clk,
  input logic rst
);

  regIdxT Rs1D, Rs2D;                 // Decode sources, x0 when idle
  regIdxT Rs1E, Rs2E;                 // Execute sources
  regIdxT RdE, RdM, RdW;              // Destinations, x0 when none
  logic   LoadE, MulE, CsrReadE;      // Execute kinds finishing in Memory
  logic   RegWriteM, RegWriteW;       // Writing instruction in M / W
  fwdSelT ForwardAE, ForwardBE;       // Operand bypass selects
  logic   LoadStallD, MulStallD, CsrStallD;

  // Pipeline side
  modport pipe (
    output Rs1D, Rs2D, Rs1E, Rs2E, RdE, RdM, RdW,
    output LoadE, MulE, CsrReadE, RegWriteM, RegWriteW,
    input  ForwardAE, ForwardBE, LoadStallD, MulStallD, CsrStallD
  );

  // Hazard unit side
  modport fwd (
    input  clk, rst,
    input  Rs1D, Rs2D, Rs1E, Rs2E, RdE, RdM, RdW,
    input  LoadE, MulE, CsrReadE, RegWriteM, RegWriteW,
    output ForwardAE, ForwardBE, LoadStallD, MulStallD, CsrStallD
  );

endinterface

`default_nettype wire

//--- regFile.sv
`default_nettype none

module regFile import isaPkg::*; (
  input  logic   clk,
  input  logic   rst,
  input  regIdxT RdAddrA,
  input  regIdxT RdAddrB,
  output wordT   RdDataA,
  output wordT   RdDataB,
  input  logic   WrEn,
  input  regIdxT WrAddr,
  input  wordT   WrData
);

  wordT regs [RegCount];

  // Write port, x0 is never stored
  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < RegCount; i++) begin
        regs[i] <= '0;
      end
    end else if (WrEn && (WrAddr != '0)) begin
      regs[WrAddr] <= WrData;
    end
  end

  // Write-first reads, covers the Writeback to Decode distance
  always_comb begin
    if (RdAddrA == '0)                     RdDataA = '0;
    else if (WrEn && (WrAddr == RdAddrA)) RdDataA = WrData;
    else                                   RdDataA = regs[RdAddrA];
    if (RdAddrB == '0)                     RdDataB = '0;
    else if (WrEn && (WrAddr == RdAddrB)) RdDataB = WrData;
    else                                   RdDataB = regs[RdAddrB];
  end

  // A write aimed at x0 must leave it reading zero afterwards
  x0StaysZero: assert property (@(posedge clk) disable iff (rst)
    (WrEn && (WrAddr == '0)) |=> (regs[0] == '0));

endmodule

`default_nettype wire

//--- forwardUnit.sv
`default_nettype none

module forwardUnit import isaPkg::*, pipePkg::*; (
  hazardIf.fwd hz
);

  logic matchDE;   // Decode source depends on Execute destination

  // Memory wins over Writeback, it holds the younger value
  function automatic fwdSelT pickSrc(
    input regIdxT rs,
    input regIdxT rdM,
    input logic   writeM,
    input regIdxT rdW,
    input logic   writeW
  );
    fwdSelT sel;
    sel = fwdNone;
    if (rs != '0) begin                         // x0 is never bypassed
      if ((rs == rdM) && writeM)      sel = fwdM;
      else if ((rs == rdW) && writeW) sel = fwdW;
    end
    return sel;
  endfunction

  ////////////////////////////////////////////////////////////
  // Operand bypass
  ////////////////////////////////////////////////////////////

  always_comb begin
    hz.ForwardAE = pickSrc(hz.Rs1E, hz.RdM, hz.RegWriteM, hz.RdW, hz.RegWriteW);
    hz.ForwardBE = pickSrc(hz.Rs2E, hz.RdM, hz.RegWriteM, hz.RdW, hz.RegWriteW);
  end

  ////////////////////////////////////////////////////////////
  // Decode stall, result only ready at the end of Memory
  ////////////////////////////////////////////////////////////

  // RdE is x0 for bubbles and non-writing ops
  assign matchDE = ((hz.Rs1D == hz.RdE) || (hz.Rs2D == hz.RdE)) && (hz.RdE != '0);

  assign hz.LoadStallD = hz.LoadE    && matchDE;   // Load data comes from RAM in M
  assign hz.MulStallD  = hz.MulE     && matchDE;   // Partial products summed in M
  assign hz.CsrStallD  = hz.CsrReadE && matchDE;   // CSR read in M

  // Execute kinds from the pipeline must be exclusive
  stallCauseOneHot: assert property (@(posedge hz.clk) disable iff (hz.rst)
    $onehot0({hz.LoadStallD, hz.MulStallD, hz.CsrStallD}));

endmodule

`default_nettype wire

//--- pipeReg.sv
`default_nettype none

module pipeReg #(
  parameter type PayloadT = logic
) (
  input  logic    clk,
  input  logic    rst,
  input  logic    Hold,      // Keep current contents
  input  logic    Bubble,    // Next stage sees an empty slot
  input  logic    InValid,
  input  PayloadT InData,
  output logic    OutValid,
  output PayloadT OutData
);

  // Valid bit is the only control state
  always_ff @(posedge clk) begin
    if (rst)         OutValid <= 1'b0;
    else if (Bubble) OutValid <= 1'b0;
    else if (!Hold)  OutValid <= InValid;
  end

  // Payload, meaningless while OutValid is low
  always_ff @(posedge clk) begin
    if (!Hold) begin
      OutData <= InData;
    end
  end

  // Hold and bubble are driven by different stall sources and must not meet
  holdBubbleExcl: assert property (@(posedge clk) disable iff (rst)
    !(Hold && Bubble));

endmodule

`default_nettype wire

//--- dataRam.sv
`default_nettype none

module dataRam import isaPkg::*; (
  input  logic clk,
  input  logic rst,
  input  wordT Addr,     // Byte address, low bits ignored
  input  logic WrEn,
  input  wordT WrData,
  output wordT RdData
);

  wordT                 mem [RamWords];
  logic [RamIdxW-1:0]   idx;

  assign idx = Addr[RamIdxW+1:2];   // Word index, upper bits wrap

  // Write on the edge ending Memory
  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < RamWords; i++) begin
        mem[i] <= '0;
      end
    end else if (WrEn) begin
      mem[idx] <= WrData;
    end
  end

  assign RdData = mem[idx];   // Combinational read within Memory

  // Stores come from the pipeline with word-aligned addresses
  wordAligned: assert property (@(posedge clk) disable iff (rst)
    WrEn |-> (Addr[1:0] == 2'b00));

endmodule

`default_nettype wire

//--- intPipe.sv
`default_nettype none

module intPipe import isaPkg::*, pipePkg::*; (
  input  logic   clk,
  input  logic   rst,
  input  logic   InValid,
  input  opT     InOp,
  input  regIdxT InRs1,
  input  regIdxT InRs2,
  input  regIdxT InRd,
  input  wordT   InImm,
  output logic   StallD,
  output logic   WbValid,
  output regIdxT WbRd,
  output wordT   WbData,
  hazardIf.pipe  hz
);

  deStageT deD, deQ;
  emStageT emD, emQ;
  mwStageT mwD, mwQ;
  logic    validE, validM, validW;
  wordT    rfA, rfB;                 // Register file read data
  wordT    srcA, srcB;               // Forwarded operands
  wordT    aluE, ramRd, mulM, resM;
  wordT    csr;                      // Scratch CSR
  logic    usesRs1, usesRs2, writesRd;

  ////////////////////////////////////////////////////////////
  // Decode
  ////////////////////////////////////////////////////////////

  assign usesRs1  = (InOp != opCsrr);
  assign usesRs2  = InOp inside {opAdd, opSub, opAnd, opOr, opXor, opStore, opMul};
  assign writesRd = !(InOp inside {opStore, opCsrw});

  // Unused sources read as x0 so they never stall or bypass
  assign hz.Rs1D = (InValid && usesRs1) ? InRs1 : '0;
  assign hz.Rs2D = (InValid && usesRs2) ? InRs2 : '0;

  regFile regFile_i (
    .clk(clk), .rst(rst),
    .RdAddrA(hz.Rs1D), .RdAddrB(hz.Rs2D), .RdDataA(rfA), .RdDataB(rfB),
    .WrEn(WbValid), .WrAddr(WbRd), .WrData(WbData)
  );

  always_comb begin
    deD.op    = InOp;
    deD.rs1   = hz.Rs1D;
    deD.rs2   = hz.Rs2D;
    deD.rd    = writesRd ? InRd : '0;   // No destination reads as x0
    deD.imm   = InImm;
    deD.a     = rfA;
    deD.b     = rfB;
    deD.write = writesRd;
  end

  assign StallD = hz.LoadStallD | hz.MulStallD | hz.CsrStallD;

  pipeReg #(.PayloadT(deStageT)) deReg_i (
    .clk(clk), .rst(rst), .Hold(1'b0), .Bubble(StallD),   // Stall turns E into a bubble
    .InValid(InValid), .InData(deD), .OutValid(validE), .OutData(deQ)
  );

  ////////////////////////////////////////////////////////////
  // Execute
  ////////////////////////////////////////////////////////////

  assign hz.Rs1E     = deQ.rs1;
  assign hz.Rs2E     = deQ.rs2;
  assign hz.RdE      = validE ? deQ.rd : '0;
  assign hz.LoadE    = validE && (deQ.op == opLoad);
  assign hz.MulE     = validE && (deQ.op == opMul);
  assign hz.CsrReadE = validE && (deQ.op == opCsrr);

  always_comb begin
    case (hz.ForwardAE)
      fwdM:    srcA = resM;
      fwdW:    srcA = mwQ.result;
      default: srcA = deQ.a;
    endcase
    case (hz.ForwardBE)
      fwdM:    srcB = resM;
      fwdW:    srcB = mwQ.result;
      default: srcB = deQ.b;
    endcase
  end

  always_comb begin
    case (deQ.op)
      opAdd:                  aluE = srcA + srcB;
      opSub:                  aluE = srcA - srcB;
      opAnd:                  aluE = srcA & srcB;
      opOr:                   aluE = srcA | srcB;
      opXor:                  aluE = srcA ^ srcB;
      opAddi, opLoad, opStore: aluE = srcA + deQ.imm;   // Also the RAM address
      default:                aluE = srcA;              // CSR write data
    endcase
  end

  always_comb begin
    emD.op        = deQ.op;
    emD.rd        = deQ.rd;
    emD.alu       = aluE;
    emD.storeData = srcB;
    emD.pLo       = {16'h0000, srcA[15:0]} * {16'h0000, srcB[15:0]};  // First multiply step
    emD.pCross    = srcA[31:16] * srcB[15:0] + srcA[15:0] * srcB[31:16]; // Only low half matters
    emD.write     = deQ.write;
  end

  pipeReg #(.PayloadT(emStageT)) emReg_i (
    .clk(clk), .rst(rst), .Hold(1'b0), .Bubble(1'b0),
    .InValid(validE), .InData(emD), .OutValid(validM), .OutData(emQ)
  );

  ////////////////////////////////////////////////////////////
  // Memory
  ////////////////////////////////////////////////////////////

  dataRam dataRam_i (
    .clk(clk), .rst(rst), .Addr(emQ.alu),
    .WrEn(validM && (emQ.op == opStore)), .WrData(emQ.storeData), .RdData(ramRd)
  );

  always_ff @(posedge clk) begin
    if (rst)                                 csr <= '0;
    else if (validM && (emQ.op == opCsrw)) csr <= emQ.alu;
  end

  assign mulM = emQ.pLo + {emQ.pCross, 16'h0000};   // Second multiply step

  always_comb begin
    if (emQ.rd == '0) resM = '0;   // x0 destination always yields zero
    else begin
      case (emQ.op)
        opLoad:  resM = ramRd;
        opMul:   resM = mulM;
        opCsrr:  resM = csr;
        default: resM = emQ.alu;
      endcase
    end
  end

  assign hz.RdM      = emQ.rd;
  assign hz.RegWriteM = validM && emQ.write;

  always_comb begin
    mwD.rd     = emQ.rd;
    mwD.result = resM;
    mwD.write  = emQ.write;
  end

  pipeReg #(.PayloadT(mwStageT)) mwReg_i (
    .clk(clk), .rst(rst), .Hold(1'b0), .Bubble(1'b0),
    .InValid(validM), .InData(mwD), .OutValid(validW), .OutData(mwQ)
  );

  ////////////////////////////////////////////////////////////
  // Writeback
  ////////////////////////////////////////////////////////////

  assign hz.RdW       = mwQ.rd;
  assign hz.RegWriteW = validW && mwQ.write;

  assign WbValid = validW && mwQ.write;   // Stores and CSR writes stay silent
  assign WbRd    = mwQ.rd;
  assign WbData  = mwQ.result;

endmodule

`default_nettype wire

//--- pipeTop.sv
`default_nettype none

module pipeTop import isaPkg::*; (
  input  logic   clk,
  input  logic   rst,
  // Pre-decoded instruction
  input  logic   InValid,
  input  opT     InOp,
  input  regIdxT InRs1,
  input  regIdxT InRs2,
  input  regIdxT InRd,
  input  wordT   InImm,
  // Source must hold its instruction while high
  output logic   StallD,
  // Register writeback
  output logic   WbValid,
  output regIdxT WbRd,
  output wordT   WbData
);

  hazardIf hz (
    .clk(clk),
    .rst(rst)
  );

  intPipe intPipe_i (
    .clk(clk),
    .rst(rst),
    .InValid(InValid),
    .InOp(InOp),
    .InRs1(InRs1),
    .InRs2(InRs2),
    .InRd(InRd),
    .InImm(InImm),
    .StallD(StallD),
    .WbValid(WbValid),
    .WbRd(WbRd),
    .WbData(WbData),
    .hz(hz.pipe)
  );

  forwardUnit forwardUnit_i (
    .hz(hz.fwd)    // Bypass selects and stall causes
  );

endmodule

`default_nettype wire

//--- pipeTb.sv
`default_nettype none

module pipeTb import isaPkg::*; ();
  timeunit 1ns;
  timeprecision 1ps;

  localparam int Period      = 40;
  localparam int RandCount   = 200;
  localparam int DirCount    = 60;                      // Directed issues, rounded up
  localparam int LimitCycles = (RandCount + DirCount) * 10 + 200;

  logic   clk = 1'b0;
  logic   rst;
  logic   InValid;
  opT     InOp;
  regIdxT InRs1;
  regIdxT InRs2;
  regIdxT InRd;
  wordT   InImm;
  logic   StallD;
  logic   WbValid;
  regIdxT WbRd;
  wordT   WbData;

  wordT        mReg [32];          // Reference register file
  wordT        mRam [RamWords];    // Reference data RAM
  wordT        mCsr;
  regIdxT      expRd [$];          // Expected writebacks in program order
  wordT        expData [$];
  int          expCyc [$];         // Cycle in which each writeback is due
  int          cyc = 0;
  int          errors = 0;
  int          errMark = 0;
  int          tests = 0;
  int          failedTests = 0;
  logic [31:0] lfsr;
  logic        prevLong;           // Last accepted op finishes in Memory
  regIdxT      prevRd;

  pipeTop pipeTop_i (
    .clk(clk), .rst(rst), .InValid(InValid), .InOp(InOp), .InRs1(InRs1), .InRs2(InRs2),
    .InRd(InRd), .InImm(InImm), .StallD(StallD), .WbValid(WbValid), .WbRd(WbRd),
    .WbData(WbData)
  );

  always #(Period / 2) clk = ~clk;
  always @(posedge clk) cyc <= cyc + 1;

  // Galois LFSR, one step per bit taken
  function automatic logic [31:0] randBits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      v    = {v[30:0], lfsr[0]};
      lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h80200003) : (lfsr >> 1);
    end
    return v;
  endfunction

  ////////////////////////////////////////////////////////////
  // Writeback monitor, sampled mid-cycle
  ////////////////////////////////////////////////////////////

  always @(negedge clk) begin
    if (!rst && WbValid) begin
      assert (expRd.size() > 0) else begin
        $display("Writeback to x%0d with nothing outstanding", WbRd);
        errors++;
      end
      if (expRd.size() > 0) begin
        assert (WbRd == expRd[0]) else begin
          $display("FAIL WbRd got %h expected %h", WbRd, expRd[0]);
          errors++;
        end
        assert (WbData == expData[0]) else begin
          $display("FAIL WbData got %h expected %h", WbData, expData[0]);
          errors++;
        end
        assert (cyc == expCyc[0]) else begin
          $display("Writeback of x%0d came in cycle %0d, due in %0d", WbRd, cyc, expCyc[0]);
          errors++;
        end
        void'(expRd.pop_front());
        void'(expData.pop_front());
        void'(expCyc.pop_front());
      end
    end else if (!rst && expCyc.size() > 0) begin
      assert (cyc <= expCyc[0]) else begin
        $display("Writeback of x%0d missing in cycle %0d", expRd[0], expCyc[0]);
        errors++;
        void'(expRd.pop_front());
        void'(expData.pop_front());
        void'(expCyc.pop_front());
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // Issue and reference model
  ////////////////////////////////////////////////////////////

  task automatic issue(input opT op, input regIdxT rs1, input regIdxT rs2,
                       input regIdxT rd, input wordT imm);
    int   stalls;
    logic useA;
    logic useB;
    logic wr;
    logic expStall;
    wordT a;
    wordT b;
    wordT addr;
    wordT res;
    stalls   = 0;
    res      = '0;
    useA     = (op != opCsrr);
    useB     = op inside {opAdd, opSub, opAnd, opOr, opXor, opStore, opMul};
    wr       = !(op inside {opStore, opCsrw});
    expStall = prevLong && (prevRd != '0) && ((useA && rs1 == prevRd) || (useB && rs2 == prevRd));
    @(negedge clk);
    InValid = 1'b1;
    InOp    = op;
    InRs1   = rs1;
    InRs2   = rs2;
    InRd    = rd;
    InImm   = imm;
    #1;
    while (StallD) begin                   // Hold the instruction
      stalls++;
      @(negedge clk);
      #1;
    end
    assert (stalls == (expStall ? 1 : 0)) else begin
      $display("Stall on %s x%0d lasted %0d cycles, expected %0d", op.name(), rd, stalls,
               expStall);
      errors++;
    end
    a    = mReg[rs1];
    b    = mReg[rs2];
    addr = a + imm;
    case (op)
      opAdd:   res = a + b;
      opSub:   res = a - b;
      opAnd:   res = a & b;
      opOr:    res = a | b;
      opXor:   res = a ^ b;
      opAddi:  res = a + imm;
      opLoad:  res = mRam[addr[7:2]];      // Word index wraps
      opStore: mRam[addr[7:2]] = b;
      opMul:   res = a * b;
      opCsrw:  mCsr = a;
      default: res = mCsr;
    endcase
    if (wr) begin
      if (rd == '0) res = '0;
      else          mReg[rd] = res;
      expRd.push_back(rd);
      expData.push_back(res);
      expCyc.push_back(cyc + 3);           // Accepting edge, then M, then W
    end
    prevLong = wr && (op inside {opLoad, opMul, opCsrr});
    prevRd   = rd;
  endtask

  task automatic idle(input int n);
    repeat (n) begin
      @(negedge clk);
      InValid = 1'b0;
    end
    prevLong = 1'b0;
  endtask

  // Drain the pipeline and print the test line
  task automatic finishTest(input string name);
    idle(1);
    repeat (10) begin
      if (expRd.size() > 0) @(negedge clk);
    end
    assert (expRd.size() == 0) else begin
      $display("%s: %0d writebacks never arrived", name, expRd.size());
      errors++;
    end
    tests++;
    if (errors == errMark) $display("test %-10s ok", name);
    else begin
      $display("test %-10s %0d errors", name, errors - errMark);
      failedTests++;
    end
    errMark = errors;
  endtask

  ////////////////////////////////////////////////////////////
  // Directed tests
  ////////////////////////////////////////////////////////////

  task automatic forwardTest();
    issue(opAddi, 5'd0, 5'd0, 5'd1, randBits(16));
    issue(opAddi, 5'd0, 5'd0, 5'd2, randBits(16));
    issue(opAdd, 5'd1, 5'd2, 5'd3, 0);      // x2 from M, x1 from W
    issue(opSub, 5'd3, 5'd1, 5'd4, 0);      // x1 through the write-first read
    issue(opXor, 5'd4, 5'd3, 5'd5, 0);
    issue(opAddi, 5'd0, 5'd0, 5'd6, 32'd1);
    issue(opAddi, 5'd6, 5'd0, 5'd6, 32'd2);
    issue(opAdd, 5'd6, 5'd6, 5'd7, 0);      // x6 in M and W, younger M wins
    issue(opOr, 5'd7, 5'd5, 5'd8, 0);
    issue(opAnd, 5'd8, 5'd4, 5'd9, 0);
    finishTest("forward");
  endtask

  task automatic zeroRegTest();
    issue(opAddi, 5'd0, 5'd0, 5'd0, 32'd123);   // Writeback shows zero
    issue(opAdd, 5'd1, 5'd2, 5'd0, 0);
    issue(opAdd, 5'd0, 5'd0, 5'd9, 0);          // x0 in M and W never bypassed
    issue(opSub, 5'd0, 5'd1, 5'd10, 0);
    issue(opMul, 5'd1, 5'd2, 5'd0, 0);
    issue(opAddi, 5'd0, 5'd0, 5'd11, 32'd9);    // No stall behind a mul to x0
    finishTest("x0");
  endtask

  task automatic loadTest();
    issue(opAddi, 5'd0, 5'd0, 5'd10, 32'h40);   // Aligned base
    issue(opAddi, 5'd0, 5'd0, 5'd11, randBits(32));
    issue(opStore, 5'd10, 5'd11, 5'd0, 32'd8);
    issue(opLoad, 5'd10, 5'd0, 5'd12, 32'd8);
    issue(opAdd, 5'd1, 5'd12, 5'd13, 0);        // One stall on rs2
    issue(opLoad, 5'd10, 5'd0, 5'd14, 32'd8);
    issue(opAddi, 5'd1, 5'd0, 5'd15, 32'd3);    // Independent follower
    issue(opLoad, 5'd10, 5'd0, 5'd14, 32'd8);
    issue(opXor, 5'd14, 5'd13, 5'd16, 0);       // One stall on rs1
    finishTest("load");
  endtask

  task automatic mulCsrTest();
    issue(opAddi, 5'd0, 5'd0, 5'd17, randBits(32));
    issue(opAddi, 5'd0, 5'd0, 5'd18, randBits(32));
    issue(opMul, 5'd17, 5'd18, 5'd19, 0);
    issue(opAdd, 5'd19, 5'd17, 5'd20, 0);       // Stall behind mul
    issue(opCsrw, 5'd20, 5'd0, 5'd0, 0);
    issue(opCsrr, 5'd0, 5'd0, 5'd21, 0);        // Sees the value just written
    issue(opXor, 5'd21, 5'd19, 5'd22, 0);       // Stall behind CSR read
    issue(opMul, 5'd22, 5'd22, 5'd23, 0);
    issue(opSub, 5'd1, 5'd23, 5'd24, 0);
    finishTest("mul/csr");
  endtask

  task automatic ramTest();
    for (int k = 0; k < 3; k++) begin
      issue(opAddi, 5'd0, 5'd0, 5'd25, randBits(32));
      issue(opStore, 5'd0, 5'd25, 5'd0, k * 4 + 256);   // Wraps onto word k
      issue(opLoad, 5'd0, 5'd0, 5'd26, k * 4);
      issue(opAdd, 5'd26, 5'd25, 5'd27, 0);
    end
    finishTest("ram");
  endtask

  task automatic randomTest();
    opT     op;
    regIdxT rs1;
    regIdxT rs2;
    regIdxT rd;
    wordT   imm;
    for (int n = 0; n < RandCount; n++) begin
      op  = opT'(4'(randBits(4) % 11));
      rs1 = regIdxT'(randBits(3));              // x0 to x7 only
      rs2 = regIdxT'(randBits(3));
      rd  = regIdxT'(randBits(3));
      imm = randBits(16);
      if (op == opStore) begin
        rs1 = '0;                               // Keeps store addresses aligned
        imm = randBits(6) << 2;
      end
      issue(op, rs1, rs2, rd, imm);
    end
    finishTest("random");
  endtask

  ////////////////////////////////////////////////////////////
  // Sequence and watchdog
  ////////////////////////////////////////////////////////////

  initial begin
    lfsr     = 32'hfa2c;
    rst      = 1'b1;
    InValid  = 1'b0;
    InOp     = opAdd;
    InRs1    = '0;
    InRs2    = '0;
    InRd     = '0;
    InImm    = '0;
    prevLong = 1'b0;
    prevRd   = '0;
    mCsr     = '0;
    for (int i = 0; i < 32; i++) mReg[i] = '0;
    for (int i = 0; i < RamWords; i++) mRam[i] = '0;
    repeat (5) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    @(negedge clk);
    assert (!StallD && !WbValid) else begin
      $display("StallD or WbValid high right after reset");
      errors++;
    end
    errMark = errors;
    forwardTest();
    zeroRegTest();
    loadTest();
    mulCsrTest();
    ramTest();
    randomTest();
    $display("Tests run %0d, with errors %0d, error count %0d", tests, failedTests, errors);
    if (failedTests == 0 && errors == 0) $display("all tests passed");
    else $display("tests failed");
    $finish;
  end

  initial begin
    #(LimitCycles * Period);
    $display("Timeout after %0d cycles, the pipeline stopped making progress", LimitCycles);
    $display("tests failed");
    $finish;
  end

endmodule

`default_nettype wire

//--- filelist.f
isaPkg.sv
pipePkg.sv
hazardIf.sv
regFile.sv
forwardUnit.sv
pipeReg.sv
dataRam.sv
intPipe.sv
pipeTop.sv
pipeTb.sv

//--- Makefile
# Verilator build and run for the pipeline testbench

VERILATOR ?= verilator
TOP       ?= pipeTb
FILELIST  ?= filelist.f
OBJDIR    ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert
PASSMSG   ?= all tests passed

SRCS := $(shell cat $(FILELIST))
SIM  := $(OBJDIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): $(FILELIST) $(SRCS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)

run: $(SIM)
	./$(SIM) > $(LOG) 2>&1; cat $(LOG)
	@grep -qx "$(PASSMSG)" $(LOG) || { echo "Simulation did not pass, see $(LOG)"; exit 1; }

clean:
	rm -rf $(OBJDIR) $(LOG)
